//--- hw/common.sv
`default_nettype none

package common;

    // basic data and address word
    typedef logic [31:0] word_t;

    // boot memory geometry
    localparam int ROM_WORDS = 1024;
    localparam int ROM_INDEX_BITS = 10;
    localparam word_t BOOT_ADDR = 32'h0000_0000;
    localparam string ROM_IMAGE = "bios.hex";

    // load opcodes, encoded as the funct3 field of a load
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_op_e;

    typedef struct packed {
        logic     valid;
        load_op_e op;
        word_t    addr;
    } load_req_t;

    typedef struct packed {
        logic  valid;
        logic  misaligned;
        logic  out_of_range;
        word_t data;
    } load_rsp_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_t;

endpackage

`default_nettype wire

//--- hw/bios_rom.sv
`default_nettype none

module bios_rom
    import common::*;
    (
        input  wire logic  clk_i,

        // port a, instruction side
        input  wire word_t read1_addr_i,
        input  wire logic  read1_enable_i,
        output wire word_t read1_data_o,

        // port b, data side
        input  wire word_t read2_addr_i,
        input  wire logic  read2_enable_i,
        output wire word_t read2_data_o
    );

    word_t mem_r [0:ROM_WORDS-1];

    // image covers only the low part, rest stays unknown
    initial begin
        $readmemh(ROM_IMAGE, mem_r);
    end

    // outputs come up as zero before the first enabled read
    word_t read1_data_r = '0;
    word_t read2_data_r = '0;

    // word index is byte address bits 11 to 2
    always_ff @(posedge clk_i) begin
        if (read1_enable_i) begin
            read1_data_r <= mem_r[read1_addr_i[ROM_INDEX_BITS+1:2]];
        end
        if (read2_enable_i) begin
            read2_data_r <= mem_r[read2_addr_i[ROM_INDEX_BITS+1:2]];
        end
    end

    assign read1_data_o = read1_data_r;
    assign read2_data_o = read2_data_r;

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit
    import common::*;
    (
        input  wire logic   clk_i,
        input  wire logic   rst_i,

        // control from the core
        input  wire logic   fetch_en_i,
        input  wire logic   redirect_i,
        input  wire word_t  redirect_addr_i,

        // rom port a
        output wire word_t  rom_addr_o,
        output wire logic   rom_enable_o,
        input  wire word_t  rom_data_i,

        // instruction stream
        output fetch_t      fetch_o
    );

    word_t pc_r;
    word_t issue_addr;

    // fetch in flight, paired with the rom word one cycle later
    logic  inflight_valid_r;
    word_t inflight_pc_r;

    // redirect target is forced to a word boundary
    assign issue_addr = redirect_i ? {redirect_addr_i[31:2], 2'b00} : pc_r;

    assign rom_addr_o   = issue_addr;
    assign rom_enable_o = fetch_en_i;

    // pc and redirect both frozen while stalled
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_r <= BOOT_ADDR;
        end else if (fetch_en_i) begin
            pc_r <= issue_addr + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            inflight_valid_r <= 1'b0;
        end else begin
            inflight_valid_r <= fetch_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_en_i) begin
            inflight_pc_r <= issue_addr;
        end
    end

    // rom output holds the word for the last issued address
    always_comb begin
        fetch_o.valid = inflight_valid_r;
        fetch_o.pc    = inflight_pc_r;
        fetch_o.instr = rom_data_i;
    end

endmodule

`default_nettype wire

//--- hw/load_unit.sv
`default_nettype none

module load_unit
    import common::*;
    (
        input  wire logic      clk_i,
        input  wire logic      rst_i,

        // load request from the core
        input  wire load_req_t load_req_i,

        // rom port b
        output wire word_t     rom_addr_o,
        output wire logic      rom_enable_o,
        input  wire word_t     rom_data_i,

        // load response, one cycle after the request
        output load_rsp_t      load_rsp_o
    );

    logic in_range;
    logic misaligned;

    // state of the request in flight
    logic     rsp_valid_r;
    logic     misaligned_r;
    logic     out_of_range_r;
    load_op_e op_r;
    logic [1:0] lane_r;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       load_data;

    // rom covers the low 4 KiB only
    assign in_range = (load_req_i.addr[31:12] == 20'h0);

    always_comb begin
        case (load_req_i.op)
            LH, LHU: misaligned = load_req_i.addr[0];
            LW:      misaligned = |load_req_i.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // out of range requests never touch the rom
    assign rom_addr_o   = load_req_i.addr;
    assign rom_enable_o = load_req_i.valid & in_range;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_r    <= 1'b0;
            misaligned_r   <= 1'b0;
            out_of_range_r <= 1'b0;
        end else begin
            rsp_valid_r <= load_req_i.valid;
            if (load_req_i.valid) begin
                misaligned_r   <= misaligned;
                out_of_range_r <= ~in_range;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_req_i.valid) begin
            op_r   <= load_req_i.op;
            lane_r <= load_req_i.addr[1:0];
        end
    end

    // byte lane and halfword pick from the returned word
    always_comb begin
        case (lane_r)
            2'd0:    byte_sel = rom_data_i[7:0];
            2'd1:    byte_sel = rom_data_i[15:8];
            2'd2:    byte_sel = rom_data_i[23:16];
            default: byte_sel = rom_data_i[31:24];
        endcase
        half_sel = lane_r[1] ? rom_data_i[31:16] : rom_data_i[15:0];
    end

    always_comb begin
        case (op_r)
            LB:      load_data = {{24{byte_sel[7]}}, byte_sel};
            LBU:     load_data = {24'h0, byte_sel};
            LH:      load_data = {{16{half_sel[15]}}, half_sel};
            LHU:     load_data = {16'h0, half_sel};
            LW:      load_data = rom_data_i;
            default: load_data = '0;
        endcase
    end

    // any fault zeroes the data
    always_comb begin
        load_rsp_o.valid        = rsp_valid_r;
        load_rsp_o.misaligned   = misaligned_r;
        load_rsp_o.out_of_range = out_of_range_r;
        if (misaligned_r || out_of_range_r) begin
            load_rsp_o.data = '0;
        end else begin
            load_rsp_o.data = load_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/boot_mem_top.sv
`default_nettype none

module boot_mem_top
    import common::*;
    (
        input  wire logic      clk_i,
        input  wire logic      rst_i,

        // instruction side
        input  wire logic      fetch_en_i,
        input  wire logic      redirect_i,
        input  wire word_t     redirect_addr_i,
        output fetch_t         fetch_o,

        // data side
        input  wire load_req_t load_req_i,
        output load_rsp_t      load_rsp_o
    );

    word_t rom_a_addr;
    logic  rom_a_enable;
    word_t rom_a_data;

    word_t rom_b_addr;
    logic  rom_b_enable;
    word_t rom_b_data;

    fetch_unit fetch_unit_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .fetch_en_i      (fetch_en_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .rom_addr_o      (rom_a_addr),
        .rom_enable_o    (rom_a_enable),
        .rom_data_i      (rom_a_data),
        .fetch_o         (fetch_o)
    );

    load_unit load_unit_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_req_i   (load_req_i),
        .rom_addr_o   (rom_b_addr),
        .rom_enable_o (rom_b_enable),
        .rom_data_i   (rom_b_data),
        .load_rsp_o   (load_rsp_o)
    );

    // port a serves fetch, port b serves loads
    bios_rom bios_rom_inst (
        .clk_i          (clk_i),
        .read1_addr_i   (rom_a_addr),
        .read1_enable_i (rom_a_enable),
        .read1_data_o   (rom_a_data),
        .read2_addr_i   (rom_b_addr),
        .read2_enable_i (rom_b_enable),
        .read2_data_o   (rom_b_data)
    );

endmodule

`default_nettype wire

//--- tb/boot_mem_properties.sv
`default_nettype none

module boot_mem_properties
    import common::*;
    (
        input wire logic      clk_i,
        input wire logic      rst_i,
        input wire logic      fetch_en_i,
        input wire load_req_t load_req_i,
        input wire fetch_t    fetch_i,
        input wire load_rsp_t load_rsp_i
    );

    // instruction comes back one cycle after the issue edge
    fetch_latency: assert property (
        @(posedge clk_i) disable iff (rst_i)
        fetch_i.valid == $past(fetch_en_i)
    ) else $error("fetch valid is not the fetch enable of the previous cycle");

    // every load request gets exactly one response, one cycle later
    load_latency: assert property (
        @(posedge clk_i) disable iff (rst_i)
        load_rsp_i.valid == $past(load_req_i.valid)
    ) else $error("load response valid is not the request valid of the previous cycle");

    // first cycle out of reset
    reset_state: assert property (
        @(posedge clk_i)
        $fell(rst_i) |-> (!fetch_i.valid && !load_rsp_i.valid)
    ) else $error("a response valid is high right after reset");

    fault_data_zero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (load_rsp_i.valid && (load_rsp_i.misaligned || load_rsp_i.out_of_range))
            |-> (load_rsp_i.data == '0)
    ) else $error("faulted load returned nonzero data");

endmodule

`default_nettype wire

//--- tb/boot_mem_tb.sv
`default_nettype none

module boot_mem_tb
    import common::*;
    ();

    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES = 2000;
    // reset plus run plus margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUN_CYCLES + 192;

    logic      clk;
    logic      rst;
    logic      fetch_en;
    logic      redirect;
    word_t     redirect_addr;
    load_req_t load_req;
    fetch_t    fetch_out;
    load_rsp_t load_rsp;

    // reference model state
    word_t       rom_model [0:ROM_WORDS-1];
    word_t       model_pc;
    logic        booted;
    logic [31:0] lfsr_state;
    fetch_t      fetch_q [$];
    load_rsp_t   load_q [$];

    int fetch_errors;
    int load_errors;
    int other_errors;
    int n_redirects;
    int n_misaligned;
    int n_out_of_range;

    boot_mem_top UUT (
        .clk_i           (clk),
        .rst_i           (rst),
        .fetch_en_i      (fetch_en),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .fetch_o         (fetch_out),
        .load_req_i      (load_req),
        .load_rsp_o      (load_rsp)
    );

    bind boot_mem_top boot_mem_properties properties_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fetch_en_i (fetch_en_i),
        .load_req_i (load_req_i),
        .fetch_i    (fetch_o),
        .load_rsp_i (load_rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step for every bit taken
    function automatic word_t rand_bits(input int n);
        word_t bits;
        int    k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic load_op_e pick_op(input word_t sel);
        case (sel)
            32'd0:   return LB;
            32'd1:   return LH;
            32'd2:   return LW;
            32'd3:   return LBU;
            default: return LHU;
        endcase
    endfunction

    // lane value of a rom word extended as the opcode asks
    function automatic word_t expected_load(input word_t w, input load_op_e op,
                                            input logic [1:0] lane);
        word_t b;
        word_t h;
        b = w >> {lane, 3'b000};
        h = w >> {lane[1], 4'b0000};
        case (op)
            LB:      return {{24{b[7]}}, b[7:0]};
            LBU:     return {24'h0, b[7:0]};
            LH:      return {{16{h[15]}}, h[15:0]};
            LHU:     return {16'h0, h[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic next_fetch(input logic active, output logic en, output logic redir,
                              output word_t target, output fetch_t exp);
        word_t r;
        word_t issue;
        r = rand_bits(3);
        en = active && (r != 32'd0);
        r = rand_bits(4);
        redir = (r == 32'd0);
        r = rand_bits(8);
        target = {24'h0, r[7:0]};
        // first fetch out of reset comes from the boot address
        if (en && !booted) begin
            redir = 1'b0;
        end
        // stay inside the loaded image
        if (en && model_pc >= 32'd252) begin
            redir = 1'b1;
        end
        exp = '0;
        if (en) begin
            issue = redir ? (target & 32'hffff_fffc) : model_pc;
            exp.valid = 1'b1;
            exp.pc    = issue;
            exp.instr = rom_model[issue[11:2]];
            model_pc  = issue + 32'd4;
            booted    = 1'b1;
            if (redir) begin
                n_redirects = n_redirects + 1;
            end
        end
    endtask

    task automatic next_load(input logic active, output load_req_t req,
                             output load_rsp_t exp);
        word_t r;
        r = rand_bits(3);
        req.valid = active && (r != 32'd0);
        r = rand_bits(3);
        req.op = pick_op(r % 32'd5);
        r = rand_bits(4);
        if (r == 32'd0) begin
            // somewhere above the 4 KiB window
            req.addr = rand_bits(32);
            if (req.addr[31:12] == 20'h0) begin
                req.addr[31] = 1'b1;
            end
        end else begin
            r = rand_bits(8);
            req.addr = {24'h0, r[7:0]};
            r = rand_bits(2);
            // mostly natural alignment
            if (r != 32'd0 && req.op == LW) begin
                req.addr[1:0] = 2'b00;
            end else if (r != 32'd0 && (req.op == LH || req.op == LHU)) begin
                req.addr[0] = 1'b0;
            end
        end
        exp = '0;
        if (req.valid) begin
            exp.valid = 1'b1;
            exp.misaligned = (req.op == LW && req.addr[1:0] != 2'b00) ||
                             ((req.op == LH || req.op == LHU) && req.addr[0]);
            exp.out_of_range = (req.addr[31:12] != 20'h0);
            if (!exp.misaligned && !exp.out_of_range) begin
                exp.data = expected_load(rom_model[req.addr[11:2]], req.op, req.addr[1:0]);
            end
            if (exp.misaligned) begin
                n_misaligned = n_misaligned + 1;
            end
            if (exp.out_of_range) begin
                n_out_of_range = n_out_of_range + 1;
            end
        end
    endtask

    task automatic check_fetch(input fetch_t exp);
        if (fetch_out.valid !== exp.valid) begin
            fetch_errors = fetch_errors + 1;
            $display("[FAIL] fetch_o.valid expected %h got %h", exp.valid, fetch_out.valid);
        end else if (exp.valid) begin
            if (fetch_out.pc !== exp.pc) begin
                fetch_errors = fetch_errors + 1;
                $display("[FAIL] fetch_o.pc expected %h got %h", exp.pc, fetch_out.pc);
            end
            if (fetch_out.instr !== exp.instr) begin
                fetch_errors = fetch_errors + 1;
                $display("[FAIL] fetch_o.instr expected %h got %h at pc %h",
                         exp.instr, fetch_out.instr, exp.pc);
            end
        end
    endtask

    task automatic check_load(input load_rsp_t exp);
        if (load_rsp.valid !== exp.valid) begin
            load_errors = load_errors + 1;
            $display("[FAIL] load_rsp_o.valid expected %h got %h", exp.valid, load_rsp.valid);
        end else if (exp.valid) begin
            if (load_rsp.misaligned !== exp.misaligned) begin
                load_errors = load_errors + 1;
                $display("[FAIL] load_rsp_o.misaligned expected %h got %h",
                         exp.misaligned, load_rsp.misaligned);
            end
            if (load_rsp.out_of_range !== exp.out_of_range) begin
                load_errors = load_errors + 1;
                $display("[FAIL] load_rsp_o.out_of_range expected %h got %h",
                         exp.out_of_range, load_rsp.out_of_range);
            end
            if (load_rsp.data !== exp.data) begin
                load_errors = load_errors + 1;
                $display("[FAIL] load_rsp_o.data expected %h got %h", exp.data, load_rsp.data);
            end
        end
    endtask

    initial begin
        fetch_t    fetch_exp;
        fetch_t    fetch_old;
        load_rsp_t load_exp;
        load_rsp_t load_old;
        load_req_t req;
        logic      active;
        logic      en;
        logic      redir;
        word_t     target;
        int        cyc;

        lfsr_state = 32'hc829;
        fetch_errors = 0;
        load_errors = 0;
        other_errors = 0;
        n_redirects = 0;
        n_misaligned = 0;
        n_out_of_range = 0;
        rst = 1'b1;
        fetch_en = 1'b0;
        redirect = 1'b0;
        redirect_addr = '0;
        load_req = '0;
        model_pc = BOOT_ADDR;
        booted = 1'b0;
        $readmemh(ROM_IMAGE, rom_model);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // nothing in flight in the first cycle out of reset
        fetch_q.push_back('0);
        load_q.push_back('0);

        for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk);
            // idle cycles at both ends of the run
            active = (cyc >= 3) && (cyc < RUN_CYCLES - 2);
            next_fetch(active, en, redir, target, fetch_exp);
            next_load(active, req, load_exp);
            fetch_en <= en;
            redirect <= redir;
            redirect_addr <= target;
            load_req <= req;
            @(negedge clk);
            fetch_old = fetch_q.pop_front();
            load_old = load_q.pop_front();
            check_fetch(fetch_old);
            check_load(load_old);
            fetch_q.push_back(fetch_exp);
            load_q.push_back(load_exp);
        end

        if (n_redirects == 0 || n_misaligned == 0 || n_out_of_range == 0) begin
            other_errors = other_errors + 1;
            $display(
                "random stimulus missed a case: %0d redirects, %0d misaligned, %0d out of range",
                n_redirects, n_misaligned, n_out_of_range);
        end
        $display("errors: %0d fetch, %0d load, %0d other", fetch_errors, load_errors,
                 other_errors);
        if (fetch_errors + load_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- bios.hex
// boot image, one 32-bit word per line, words 0 to 63
43FD8100
47F98504
4BF58908
4FF18D0C
53ED9110
57E99514
5BE59918
5FE19D1C
63DDA120
67D9A524
6BD5A928
6FD1AD2C
73CDB130
77C9B534
7BC5B938
7FC1BD3C
83BDC140
87B9C544
8BB5C948
8FB1CD4C
93ADD150
97A9D554
9BA5D958
9FA1DD5C
A39DE160
A799E564
AB95E968
AF91ED6C
B38DF170
B789F574
BB85F978
BF81FD7C
C37D0180
C7790584
CB750988
CF710D8C
D36D1190
D7691594
DB651998
DF611D9C
E35D21A0
E75925A4
EB5529A8
EF512DAC
F34D31B0
F74935B4
FB4539B8
FF413DBC
033D41C0
073945C4
0B3549C8
0F314DCC
132D51D0
172955D4
1B2559D8
1F215DDC
231D61E0
271965E4
2B1569E8
2F116DEC
330D71F0
370975F4
3B0579F8
3F017DFC

//--- build.f
hw/common.sv
hw/bios_rom.sv
hw/fetch_unit.sv
hw/load_unit.sv
hw/boot_mem_top.sv
tb/boot_mem_properties.sv
tb/boot_mem_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --assert -j 0 --top-module boot_mem_tb -Mdir obj_dir -f build.f
	./obj_dir/Vboot_mem_tb | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
